//--- Bender.yml
package:
  name: snd_board

export_include_dirs:
  - include

sources:
  - src/snd_pkg.sv
  - src/snd_bus_if.sv
  - src/snd_mem_map.sv
  - src/snd_rom_fetch.sv
  - src/snd_sample_timer.sv
  - src/snd_mix_filter.sv
  - src/snd_top.sv
  - target: simulation
    files:
      - sim/snd_assert.sv
      - sim/snd_tb.sv

//--- include/snd_config.svh
`ifndef SND_CONFIG_SVH
`define SND_CONFIG_SVH

// FM gain in 4.4 fixed point, 0x10 is unity
`define SND_FM_GAIN 8'h10

// One-pole coefficient a, pole near 4 kHz
// Filter step weight is 16 - a
`define SND_POLE_A 4'd10

// cen_fm pulses per output sample
`define SND_SAMPLE_DIV 64

// Work RAM address width, 2 KB
`define SND_RAM_AW 11

`endif

//--- project.f
+incdir+include
src/snd_pkg.sv
src/snd_bus_if.sv
src/snd_mem_map.sv
src/snd_rom_fetch.sv
src/snd_sample_timer.sv
src/snd_mix_filter.sv
src/snd_top.sv
sim/snd_assert.sv
sim/snd_tb.sv

//--- sim/snd_assert.sv
`timescale 1ns/1ps

module snd_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 cpu_mreq_n,
    input logic                 cpu_rd_n,
    input logic                 cpu_wr_n,
    input snd_pkg::snd_region_e region,
    input logic                 rom_cs,
    input logic                 cpu_wait_n,
    input logic                 pcm_rst
);
    logic rom_rd;   // CPU read in either ROM window
    logic misc_wr;

    assign rom_rd  = (region == snd_pkg::rgn_rom || region == snd_pkg::rgn_bank)
                     && !cpu_mreq_n && !cpu_rd_n;
    assign misc_wr = (region == snd_pkg::rgn_misc) && !cpu_wr_n;

    // ROM is only selected while the CPU is stalled
    cs_in_wait: assert property (@(posedge clk) disable iff (rst) rom_cs |-> !cpu_wait_n)
        else $error("rom_cs high while wait_n is high");

    read_stalls: assert property (@(posedge clk) disable iff (rst) $rose(rom_rd) |=> !cpu_wait_n)
        else $error("wait_n not low after ROM read start");

    cs_bounded: assert property (@(posedge clk) disable iff (rst)
        $rose(rom_cs) |-> ##[1:64] !rom_cs)
        else $error("rom_cs held high for more than 64 cycles");

    // PCM reset only comes back through the misc latch
    pcm_rst_src: assert property (@(posedge clk) disable iff (rst)
        $rose(pcm_rst) |-> $past(misc_wr) || $past(rst))
        else $error("pcm_rst rose without a misc write");
endmodule

bind snd_top snd_assert i_assert (
    .clk        (clk),
    .rst        (rst),
    .cpu_mreq_n (cpu_mreq_n),
    .cpu_rd_n   (cpu_rd_n),
    .cpu_wr_n   (cpu_wr_n),
    .region     (region),
    .rom_cs     (rom_cs),
    .cpu_wait_n (cpu_wait_n),
    .pcm_rst    (pcm_rst)
);

//--- sim/snd_input.txt
// op addr data expected, all hex; op 0 mem rd, 1 mem wr, 2 io rd, 3 io wr, 4 options
// 5 channels (fm_left fm_right pcm), 6 wait N samples, f end; ROM reads expect rom_addr
0 8123 0 10123
0 1234 0 01234
3 0040 05 3
0 9abc 0 15abc
3 0040 4e 2
0 c001 0 28001
3 0040 bf 1
0 dfff 0 4dfff
3 007f d0 0
0 a5a5 0 325a5
0 7fff 0 07fff
1 1234 99 0
0 1234 0 01234
1 f800 11 0
1 fa55 a5 0
1 ffff 3c 0
0 f800 0 11
0 fa55 0 a5
0 ffff 0 3c
0 e000 0 ff
0 f7ff 0 ff
0 e800 0 c3
1 eabc 77 77
2 0000 0 5a
2 0080 0 7f
2 00c0 0 c3
3 00c1 42 42
3 0040 40 2
5 0100 ff00 064
4 0 c 0
6 0 4 0
4 0 d 0
6 0 2 0
4 0 e 0
6 0 2 0
4 0 f 0
6 0 2 0
4 0 8 0
6 0 2 0
4 0 4 0
6 0 2 0
5 0000 0000 1a0
4 0 f 0
6 0 3 0
5 7fff 7fff 0ff
6 0 2 0
5 8000 8000 100
6 0 2 0
f 0 0 0

//--- sim/snd_tb.sv
`timescale 1ns/1ps
`include "snd_config.svh"

module snd_tb;
    localparam int step_k   = 16 - `SND_POLE_A;       // filter step weight
    localparam int wait_max = 64;                      // cycles allowed for a ROM read
    localparam int smp_max  = 2 * `SND_SAMPLE_DIV + 8; // cycles between strobes, with margin
    localparam int rec_max  = 256;                     // four words per record

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 cen_fm;
    logic [1:0]           fxlevel;
    logic                 enable_fm, enable_psg;
    logic [15:0]          cpu_addr;
    logic                 cpu_mreq_n, cpu_iorq_n, cpu_rd_n, cpu_wr_n;
    logic [7:0]           cpu_dout;
    logic [7:0]           cpu_din;
    logic                 cpu_wait_n, cpu_int_n;
    logic                 mapper_rd, mapper_wr, mapper_obf;
    logic [7:0]           mapper_din, mapper_dout;
    logic [18:0]          rom_addr;
    logic                 rom_cs, rom_ok;
    logic [7:0]           rom_data;
    logic                 fm_cs_n;
    logic [7:0]           fm_dout;
    snd_pkg::fm_sample_t  fm_left, fm_right, snd;
    logic                 pcm_cs, pcm_rst, pcm_mdn, pcm_busyn;
    snd_pkg::pcm_sample_t pcm_raw;
    logic                 sample, peak;

    logic [19:0] recs [0:rec_max-1];  // op, addr, data, expected
    logic [15:0] lfsr = 16'd8705;
    logic [3:0]  draw;                // fresh random bits for one request
    int          draw_i;
    logic        mem_busy = 1'b0;
    logic [2:0]  ok_delay;
    logic        ok_glitch;           // drop ok for one cycle after it first rises
    logic [3:0]  ok_step;
    int          y_model = 0;         // filter state as the model sees it
    int          cen_seen = 0;        // FM enables since the last strobe
    int          check_count = 0;
    int          error_count = 0;

    snd_top i_dut (.*);

    always #4 clk = ~clk;

    // FM enable every other cycle
    always @(posedge clk) cen_fm <= rst ? 1'b0 : ~cen_fm;

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Slow ROM: byte is low address byte XOR high byte, ok after 0 to 7 cycles
    always @(posedge clk) begin
        rom_data <= rom_addr[7:0] ^ rom_addr[15:8];
        if (!rom_cs) begin
            mem_busy <= 1'b0;
            rom_ok   <= 1'b0;
        end else if (!mem_busy) begin
            for (draw_i = 0; draw_i < 4; draw_i++) begin
                lfsr         = lfsr_step(lfsr);
                draw[draw_i] = lfsr[0];    // one step per bit
            end
            mem_busy  <= 1'b1;
            ok_delay  <= draw[2:0];
            ok_glitch <= draw[3];
            ok_step   <= 4'd0;
        end else begin
            ok_step <= ok_step + 4'd1;
            rom_ok  <= (ok_step >= ok_delay) && !(ok_glitch && ok_step == ok_delay + 4'd1);
        end
    end

    // One-pole filter model, stepped on every strobe since reset
    always @(negedge clk) begin
        if (!rst && sample)
            y_model = y_model + (((int'(pcm_raw) - y_model) * step_k) >>> 4);
    end

    // Strobe closes each group of FM enables
    always @(negedge clk) begin
        if (rst) begin
            cen_seen = 0;
        end else begin
            assert (!sample || cen_fm) else begin
                error_count++;
                $display("Sample strobe outside an FM clock enable");
            end
            if (cen_fm)
                cen_seen = cen_seen + 1;
            if (sample) begin
                compare_value("sample", cen_seen, `SND_SAMPLE_DIV);
                cen_seen = 0;
            end
        end
    end

    // Expected {peak, snd} from the gain and clip rules
    function automatic logic [16:0] mix_expect(input int y);
        int fg;
        int pg;
        int sum;
        fg = enable_fm ? int'(`SND_FM_GAIN) : 0;
        case (fxlevel)
            2'd0:    pg = 4;
            2'd1:    pg = 6;
            2'd2:    pg = 8;
            default: pg = 12;
        endcase
        if (!enable_psg)
            pg = 0;
        sum = ((int'(fm_left) + int'(fm_right)) * fg + y * pg) >>> 4;
        if (sum > 32767)
            return {1'b1, 16'h7fff};
        else if (sum < -32768)
            return {1'b1, 16'h8000};
        return {1'b0, 16'(sum)};
    endfunction

    task automatic compare_value(input string name, input logic [19:0] got,
                                 input logic [19:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Read cycle, held while wait_n is low
    task automatic bus_read(input logic io, input logic [15:0] addr, input logic [19:0] exp);
        logic rom_hit;
        logic map_hit;
        int   n;
        rom_hit = !io && addr < 16'he000;
        map_hit = io ? addr[7:6] == 2'd3 : addr[15:11] == 5'b11101;
        @(posedge clk);
        cpu_addr   <= addr;
        cpu_mreq_n <= io;
        cpu_iorq_n <= !io;
        cpu_rd_n   <= 1'b0;
        @(negedge clk);
        if (rom_hit) begin
            compare_value("rom_addr", rom_addr, exp);
            compare_value("cpu_wait_n", cpu_wait_n, 0);  // stall from the first cycle
        end
        if (io && addr[7:6] == 2'd0)
            compare_value("fm_cs_n", fm_cs_n, 0);
        if (io && addr[7:6] == 2'd2)
            compare_value("pcm_cs", pcm_cs, 1);
        if (map_hit)
            compare_value("mapper_rd", mapper_rd, 1);
        n = 0;
        do begin
            @(posedge clk);
            @(negedge clk);
            n++;
        end while (!cpu_wait_n && n < wait_max);
        assert (cpu_wait_n) else begin
            error_count++;
            $display("Timeout: wait_n still low after %0d cycles at address %h", n, addr);
        end
        if (cpu_wait_n)
            compare_value("cpu_din", cpu_din, rom_hit ? exp[7:0] ^ exp[15:8] : exp[7:0]);
        @(posedge clk);
        cpu_mreq_n <= 1'b1;
        cpu_iorq_n <= 1'b1;
        cpu_rd_n   <= 1'b1;
    endtask

    task automatic bus_write(input logic io, input logic [15:0] addr, input logic [7:0] data,
                             input logic [19:0] exp);
        @(posedge clk);
        cpu_addr   <= addr;
        cpu_dout   <= data;
        cpu_mreq_n <= io;
        cpu_iorq_n <= !io;
        cpu_wr_n   <= 1'b0;
        @(negedge clk);
        if (io ? addr[7:6] == 2'd3 : addr[15:11] == 5'b11101) begin
            compare_value("mapper_wr", mapper_wr, 1);
            compare_value("mapper_din", mapper_din, exp);
        end
        @(posedge clk);     // first edge of the strobe
        @(negedge clk);
        if (io && addr[7:6] == 2'd1)
            compare_value("pcm_mdn,pcm_rst", {pcm_mdn, pcm_rst}, exp);
        @(posedge clk);
        cpu_mreq_n <= 1'b1;
        cpu_iorq_n <= 1'b1;
        cpu_wr_n   <= 1'b1;
    endtask

    // snd and peak land one cycle after the filter step
    task automatic check_samples(input int count);
        logic [16:0] exp;
        int          i;
        int          n;
        for (i = 0; i < count; i++) begin
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!sample && n < smp_max);
            assert (sample) else begin
                error_count++;
                $display("Timeout: no sample strobe within %0d cycles", smp_max);
            end
            @(posedge clk);
            @(posedge clk);
            @(negedge clk);
            exp = mix_expect(y_model);
            compare_value("snd", $unsigned(snd), exp[15:0]);
            compare_value("peak", peak, exp[16]);
        end
    endtask

    initial begin
        int          idx;
        logic [19:0] op;
        logic [19:0] a;
        logic [19:0] d;
        logic [19:0] e;
        rst        = 1'b1;
        cen_fm     = 1'b0;
        fxlevel    = 2'd0;
        enable_fm  = 1'b0;
        enable_psg = 1'b0;
        cpu_addr   = 16'h0000;
        cpu_mreq_n = 1'b1;
        cpu_iorq_n = 1'b1;
        cpu_rd_n   = 1'b1;
        cpu_wr_n   = 1'b1;
        cpu_dout   = 8'h00;
        mapper_dout = 8'hc3;
        mapper_obf = 1'b0;
        rom_data   = 8'h00;
        rom_ok     = 1'b0;
        fm_dout    = 8'h5a;
        fm_left    = '0;
        fm_right   = '0;
        pcm_busyn  = 1'b0;   // PCM busy, status reads 0x7F
        pcm_raw    = '0;
        $readmemh("sim/snd_input.txt", recs);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value("rom_cs", rom_cs, 0);
        compare_value("cpu_wait_n", cpu_wait_n, 1);
        compare_value("mapper_rd", mapper_rd, 0);
        compare_value("mapper_wr", mapper_wr, 0);
        compare_value("pcm_rst", pcm_rst, 1);
        compare_value("pcm_mdn", pcm_mdn, 1);
        compare_value("sample", sample, 0);
        compare_value("snd", $unsigned(snd), 0);
        compare_value("peak", peak, 0);
        @(posedge clk);
        mapper_obf <= 1'b1;
        @(negedge clk);
        compare_value("cpu_int_n", cpu_int_n, 0);
        @(posedge clk);
        mapper_obf <= 1'b0;
        @(negedge clk);
        compare_value("cpu_int_n", cpu_int_n, 1);

        idx = 0;
        op  = recs[0];
        while (op[3:0] !== 4'hf && idx < rec_max) begin
            a = recs[idx + 1];
            d = recs[idx + 2];
            e = recs[idx + 3];
            case (op[3:0])
                4'h0: bus_read(1'b0, a[15:0], e);
                4'h1: bus_write(1'b0, a[15:0], d[7:0], e);
                4'h2: bus_read(1'b1, a[15:0], e);
                4'h3: bus_write(1'b1, a[15:0], d[7:0], e);
                4'h4: begin
                    @(posedge clk);
                    fxlevel    <= d[1:0];
                    enable_fm  <= d[2];
                    enable_psg <= d[3];
                end
                4'h5: begin
                    @(posedge clk);
                    fm_left  <= a[15:0];
                    fm_right <= d[15:0];
                    pcm_raw  <= e[8:0];
                end
                4'h6: check_samples(int'(d));
                default: begin
                    error_count++;
                    $display("Unknown operation %h in record %0d", op, idx / 4);
                    idx = rec_max;
                end
            endcase
            idx += 4;
            op = (idx < rec_max) ? recs[idx] : 20'hx;
        end
        assert (op[3:0] === 4'hf) else begin
            error_count++;
            $display("Stimulus file ended without an end record");
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Hard stop if something hangs
    initial begin
        #200000;
        $display("Simulation time limit reached");
        $display("Test failures found");
        $finish;
    end
endmodule

//--- src/snd_bus_if.sv
`timescale 1ns/1ps

// Z80 bus as seen by the glue logic
interface snd_bus_if;
    logic [15:0] addr;
    logic        mreq_n;   // memory request
    logic        iorq_n;   // I/O request
    logic        rd_n;
    logic        wr_n;
    logic [7:0]  wdata;    // CPU data out

    // Decoder sees the whole bus
    modport mem (
        input addr,
        input mreq_n,
        input iorq_n,
        input rd_n,
        input wr_n,
        input wdata
    );

    // ROM fetch only needs the read cycle
    modport fetch (
        input mreq_n,
        input rd_n
    );
endinterface

//--- src/snd_mem_map.sv
`timescale 1ns/1ps
`include "snd_config.svh"

module snd_mem_map (
    input  logic                 clk,
    input  logic                 rst,
    snd_bus_if.mem               bus,
    output snd_pkg::snd_region_e region,
    output logic [18:0]          rom_addr,
    input  logic [7:0]           rom_q,
    input  logic [7:0]           fm_dout,
    input  logic [7:0]           mapper_dout,
    input  logic                 pcm_busyn,
    output logic [7:0]           cpu_din,
    output logic                 fm_cs_n,
    output logic                 mapper_rd,
    output logic                 mapper_wr,
    output logic [7:0]           mapper_din,
    output logic                 pcm_cs,
    output logic                 pcm_rst,
    output logic                 pcm_mdn
);
    logic [5:0] bank_bits;   // misc latch D5-D0
    logic [1:0] bank_hi;     // ROM A17-A16 for the bank window
    logic [7:0] ram [0:(1 << `SND_RAM_AW) - 1];
    logic [7:0] ram_q;

    // Port map first, Z80 never has both requests low
    always_comb begin
        region = snd_pkg::rgn_none;
        if (!bus.iorq_n) begin
            case (bus.addr[7:6])
                2'd0:    region = snd_pkg::rgn_fm;
                2'd1:    region = snd_pkg::rgn_misc;
                2'd2:    region = snd_pkg::rgn_pcm;
                default: region = snd_pkg::rgn_mapper;
            endcase
        end else if (!bus.mreq_n) begin
            if (!bus.addr[15])
                region = snd_pkg::rgn_rom;
            else if (bus.addr[15:12] < 4'he)
                region = snd_pkg::rgn_bank;           // 8000-DFFF
            else if (bus.addr[15:11] == 5'b11101)
                region = snd_pkg::rgn_mapper;         // E800-EFFF
            else if (bus.addr[15:11] == 5'b11111)
                region = snd_pkg::rgn_ram;            // F800-FFFF
        end
    end

    // 171-5358 board, highest set bit of D5-D2 picks the ROM socket
    always_comb begin
        casez (bank_bits[5:2])
            4'b1???: bank_hi = 2'd3;
            4'b01??: bank_hi = 2'd2;
            4'b001?: bank_hi = 2'd1;
            default: bank_hi = 2'd0;  // D2 alone or none
        endcase
    end

    always_comb begin
        if (region == snd_pkg::rgn_bank)
            rom_addr = {1'b0, bank_hi, bank_bits[1:0], bus.addr[13:0]} + 19'h10000;
        else
            rom_addr = {3'd0, bus.addr};  // fixed ROM maps straight through
    end

    // Chip selects and mapper strobes
    assign fm_cs_n    = (region != snd_pkg::rgn_fm);
    assign pcm_cs     = (region == snd_pkg::rgn_pcm);
    assign mapper_rd  = (region == snd_pkg::rgn_mapper) && !bus.rd_n;
    assign mapper_wr  = (region == snd_pkg::rgn_mapper) && !bus.wr_n;
    assign mapper_din = bus.wdata;

    // Misc latch, D6 and D7 are active-low on the board
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_bits <= 6'd0;
            pcm_rst   <= 1'b1;   // PCM held in reset
            pcm_mdn   <= 1'b1;   // stand-alone mode
        end else if (region == snd_pkg::rgn_misc && !bus.wr_n) begin
            bank_bits <= bus.wdata[5:0];
            pcm_rst   <= ~bus.wdata[6];
            pcm_mdn   <= ~bus.wdata[7];
        end
    end

    // Work RAM
    always_ff @(posedge clk) begin
        if (region == snd_pkg::rgn_ram && !bus.wr_n)
            ram[bus.addr[`SND_RAM_AW-1:0]] <= bus.wdata;
    end

    assign ram_q = ram[bus.addr[`SND_RAM_AW-1:0]];

    // Read mux, one cycle behind the strobe
    always_ff @(posedge clk) begin
        case (region)
            snd_pkg::rgn_rom,
            snd_pkg::rgn_bank:   cpu_din <= rom_q;        // held by the fetch FSM
            snd_pkg::rgn_ram:    cpu_din <= ram_q;
            snd_pkg::rgn_fm:     cpu_din <= fm_dout;
            snd_pkg::rgn_pcm:    cpu_din <= {pcm_busyn, 7'h7f};  // busy over ones
            snd_pkg::rgn_mapper: cpu_din <= mapper_dout;
            default:             cpu_din <= 8'hff;         // misc and unmapped
        endcase
    end
endmodule

//--- src/snd_mix_filter.sv
`timescale 1ns/1ps
`include "snd_config.svh"

module snd_mix_filter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sample,
    input  logic [1:0]           fxlevel,
    input  logic                 enable_fm,
    input  logic                 enable_psg,
    input  snd_pkg::fm_sample_t  fm_left,
    input  snd_pkg::fm_sample_t  fm_right,
    input  snd_pkg::pcm_sample_t pcm_raw,
    output snd_pkg::fm_sample_t  snd,
    output logic                 peak
);
    localparam logic signed [5:0] step_k = 6'sd16 - $signed({2'b00, `SND_POLE_A});

    snd_pkg::gain_t       fm_gain;
    snd_pkg::gain_t       pcm_gain;
    snd_pkg::pcm_sample_t pcm_flt;     // filter state
    logic                 mix_en;      // sample seen last cycle
    logic signed [9:0]    flt_diff;
    logic signed [15:0]   flt_prod;
    logic signed [26:0]   mix_sum;
    logic signed [26:0]   mix_sh;

    assign fm_gain = enable_fm ? `SND_FM_GAIN : 8'h00;

    // PCM level from the option switch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pcm_gain <= 8'h00;
        end else if (!enable_psg) begin
            pcm_gain <= 8'h00;
        end else begin
            case (fxlevel)
                2'd0:    pcm_gain <= 8'h04;
                2'd1:    pcm_gain <= 8'h06;
                2'd2:    pcm_gain <= 8'h08;
                default: pcm_gain <= 8'h0c;
            endcase
        end
    end

    // y += ((x - y) * (16 - a)) >>> 4
    assign flt_diff = pcm_raw - pcm_flt;
    assign flt_prod = flt_diff * step_k;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pcm_flt <= '0;
            mix_en  <= 1'b0;
        end else begin
            mix_en <= sample;
            if (sample)
                pcm_flt <= pcm_flt + 9'(flt_prod >>> 4);  // stays between x and y
        end
    end

    // Weighted sum, gains are unsigned 4.4
    assign mix_sum = fm_left  * $signed({1'b0, fm_gain})
                   + fm_right * $signed({1'b0, fm_gain})
                   + pcm_flt  * $signed({1'b0, pcm_gain});
    assign mix_sh  = mix_sum >>> 4;

    // Clip to 16 bits, flag the clip
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd  <= '0;
            peak <= 1'b0;
        end else if (mix_en) begin
            if (mix_sh > 27'sd32767) begin
                snd  <= 16'sh7fff;
                peak <= 1'b1;
            end else if (mix_sh < -27'sd32768) begin
                snd  <= 16'sh8000;
                peak <= 1'b1;
            end else begin
                snd  <= mix_sh[15:0];
                peak <= 1'b0;
            end
        end
    end
endmodule

//--- src/snd_pkg.sv
package snd_pkg;

    // Region hit by the current CPU access
    typedef enum logic [2:0] {
        rgn_none   = 3'd0,  // unmapped, reads 0xFF
        rgn_rom    = 3'd1,  // fixed ROM 0000-7FFF
        rgn_bank   = 3'd2,  // banked ROM 8000-DFFF
        rgn_ram    = 3'd3,  // work RAM F800-FFFF
        rgn_fm     = 3'd4,  // YM2151 port
        rgn_misc   = 3'd5,  // bank and PCM control latch
        rgn_pcm    = 3'd6,  // uPD7759 port
        rgn_mapper = 3'd7   // 315-5195 mapper, port or E800
    } snd_region_e;

    // Raw PCM from the uPD7759
    typedef logic signed [8:0] pcm_sample_t;

    // FM channel and final mix
    typedef logic signed [15:0] fm_sample_t;

    // Channel gain, 4.4 fixed point
    typedef logic [7:0] gain_t;

endpackage

//--- src/snd_rom_fetch.sv
`timescale 1ns/1ps

module snd_rom_fetch (
    input  logic                 clk,
    input  logic                 rst,
    snd_bus_if.fetch             bus,
    input  snd_pkg::snd_region_e region,
    output logic                 rom_cs,
    input  logic [7:0]           rom_data,
    input  logic                 rom_ok,
    output logic [7:0]           rom_q,
    output logic                 wait_n
);
    typedef enum logic [1:0] {
        st_idle,
        st_request,  // rom_cs up, looking for first ok
        st_settle,   // ok seen once
        st_done      // byte latched, waiting for strobe end
    } fetch_state_e;

    fetch_state_e state;
    logic         rom_rd;  // CPU read in either ROM window
    logic         rdy;     // cpu_din has the byte

    assign rom_rd = (region == snd_pkg::rgn_rom || region == snd_pkg::rgn_bank)
                    && !bus.mreq_n && !bus.rd_n;

    // Stall right away, release once the byte reached cpu_din
    assign wait_n = !rom_rd || rdy;
    assign rom_cs = rom_rd && (state == st_request || state == st_settle);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            rdy   <= 1'b0;
        end else begin
            rdy <= rom_rd && (state == st_done);  // one cycle for the read mux
            case (state)
                st_idle:    if (rom_rd) state <= st_request;
                st_request: begin
                    if (!rom_rd)     state <= st_idle;
                    else if (rom_ok) state <= st_settle;
                end
                st_settle: begin
                    if (!rom_rd)     state <= st_idle;
                    else if (rom_ok) state <= st_done;
                    else             state <= st_request;  // ok glitched low
                end
                default:    if (!rom_rd) state <= st_idle;
            endcase
        end
    end

    // Capture on the second consecutive ok
    always_ff @(posedge clk) begin
        if (state == st_settle && rom_ok && rom_rd)
            rom_q <= rom_data;
    end
endmodule

//--- src/snd_sample_timer.sv
`timescale 1ns/1ps
`include "snd_config.svh"

module snd_sample_timer (
    input  logic clk,
    input  logic rst,
    input  logic cen_fm,
    output logic sample
);
    localparam int cnt_w = $clog2(`SND_SAMPLE_DIV);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`SND_SAMPLE_DIV - 1);

    logic [cnt_w-1:0] cnt;  // FM enables within the current sample

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cen_fm) begin
            if (cnt == cnt_last)
                cnt <= '0;   // wrap
            else
                cnt <= cnt + 1'b1;
        end
    end

    // Strobe on the enable that completes the group
    assign sample = cen_fm && (cnt == cnt_last);
endmodule

//--- src/snd_top.sv
`timescale 1ns/1ps

module snd_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen_fm,
    input  logic [1:0]           fxlevel,
    input  logic                 enable_fm,
    input  logic                 enable_psg,
    input  logic [15:0]          cpu_addr,
    input  logic                 cpu_mreq_n,
    input  logic                 cpu_iorq_n,
    input  logic                 cpu_rd_n,
    input  logic                 cpu_wr_n,
    input  logic [7:0]           cpu_dout,
    output logic [7:0]           cpu_din,
    output logic                 cpu_wait_n,
    output logic                 cpu_int_n,
    output logic                 mapper_rd,
    output logic                 mapper_wr,
    output logic [7:0]           mapper_din,
    input  logic [7:0]           mapper_dout,
    input  logic                 mapper_obf,
    output logic [18:0]          rom_addr,
    output logic                 rom_cs,
    input  logic [7:0]           rom_data,
    input  logic                 rom_ok,
    output logic                 fm_cs_n,
    input  logic [7:0]           fm_dout,
    input  snd_pkg::fm_sample_t  fm_left,
    input  snd_pkg::fm_sample_t  fm_right,
    output logic                 pcm_cs,
    output logic                 pcm_rst,
    output logic                 pcm_mdn,
    input  logic                 pcm_busyn,
    input  snd_pkg::pcm_sample_t pcm_raw,
    output snd_pkg::fm_sample_t  snd,
    output logic                 sample,
    output logic                 peak
);
    snd_pkg::snd_region_e region;
    logic [7:0]           rom_q;

    snd_bus_if bus ();

    // CPU pins onto the internal bus
    assign bus.addr   = cpu_addr;
    assign bus.mreq_n = cpu_mreq_n;
    assign bus.iorq_n = cpu_iorq_n;
    assign bus.rd_n   = cpu_rd_n;
    assign bus.wr_n   = cpu_wr_n;
    assign bus.wdata  = cpu_dout;

    assign cpu_int_n = ~mapper_obf;  // mapper buffer full interrupts the Z80

    snd_mem_map i_mem_map (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus.mem),
        .region      (region),
        .rom_addr    (rom_addr),
        .rom_q       (rom_q),
        .fm_dout     (fm_dout),
        .mapper_dout (mapper_dout),
        .pcm_busyn   (pcm_busyn),
        .cpu_din     (cpu_din),
        .fm_cs_n     (fm_cs_n),
        .mapper_rd   (mapper_rd),
        .mapper_wr   (mapper_wr),
        .mapper_din  (mapper_din),
        .pcm_cs      (pcm_cs),
        .pcm_rst     (pcm_rst),
        .pcm_mdn     (pcm_mdn)
    );

    snd_rom_fetch i_rom_fetch (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus.fetch),
        .region   (region),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .rom_q    (rom_q),
        .wait_n   (cpu_wait_n)
    );

    snd_sample_timer i_sample_timer (
        .clk    (clk),
        .rst    (rst),
        .cen_fm (cen_fm),
        .sample (sample)
    );

    snd_mix_filter i_mix_filter (
        .clk        (clk),
        .rst        (rst),
        .sample     (sample),
        .fxlevel    (fxlevel),
        .enable_fm  (enable_fm),
        .enable_psg (enable_psg),
        .fm_left    (fm_left),
        .fm_right   (fm_right),
        .pcm_raw    (pcm_raw),
        .snd        (snd),
        .peak       (peak)
    );
endmodule
